//--- project.f
common/vgc_pkg.sv
shr/shr_fetch_sequencer.sv
shr/shr_palette_ram.sv
shr/shr_pixel_decoder.sv
logic/vgc_raster_out.sv
logic/shr_vgc.sv
tb/shr_vgc_checker.sv
tb/tb_shr_vgc.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = tb_shr_vgc
FILELIST  = project.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = tests failed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb/tb_shr_vgc.sv
`default_nettype none

module tb_shr_vgc import vgc_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    // A base other than the default shows that every address follows it
    localparam vid_addr_t BASE        = 23'h0e0000;
    localparam int        FRAMES      = 4;
    localparam int        LINE_LEN    = 916;
    localparam int        FRAME_LINES = 262;
    // Twice the run length, with ce_pix high on about every second clock
    localparam longint WATCHDOG_NS = 2 * FRAMES * FRAME_LINES * LINE_LEN * 2 * 10;

    logic       clk_vid;
    logic       reset;
    logic       ce_pix;
    logic [9:0] h_pos;
    logic [8:0] v_pos;
    logic       shr_enable;
    nibble_t    border_color;
    logic [7:0] video_data;
    vid_addr_t  video_addr;
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
    logic       scanline_irq;
    logic       vbl_irq;

    // Video memory image, indexed by the offset from the bank base
    logic [7:0]  mem [65536];
    vid_addr_t   addr_held;
    nibble_t     model_border;
    nibble_t     fill_last;
    logic        model_irq;
    logic        stepped;
    int          errors;
    int          checks;
    int          frames;
    int          vbl_seen;

    shr_vgc #(
        .MEM_BASE (BASE)
    ) u_shr_vgc (
        .clk_vid      (clk_vid),
        .reset        (reset),
        .ce_pix       (ce_pix),
        .h_pos        (h_pos),
        .v_pos        (v_pos),
        .shr_enable   (shr_enable),
        .border_color (border_color),
        .video_data   (video_data),
        .video_addr   (video_addr),
        .red          (red),
        .green        (green),
        .blue         (blue),
        .scanline_irq (scanline_irq),
        .vbl_irq      (vbl_irq)
    );

    bind shr_vgc shr_vgc_checker u_checker (
        .clk_vid      (clk_vid),
        .reset        (reset),
        .ce_pix       (ce_pix),
        .shr_enable   (shr_enable),
        .video_addr   (video_addr),
        .red          (red),
        .green        (green),
        .blue         (blue),
        .scanline_irq (scanline_irq),
        .vbl_irq      (vbl_irq)
    );

    initial begin
        clk_vid = 1'b0;
        forever #5 clk_vid = ~clk_vid;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before %0d frames were completed", FRAMES);
        $display("tests failed");
        $finish;
    end

    function automatic logic [7:0] mem_at(input int offset);
        return mem[offset[15:0]];
    endfunction

    // Addresses outside the image answer with a byte made from the whole address
    function automatic logic [7:0] memory_read(input vid_addr_t addr);
        vid_addr_t offset;
        offset = addr - BASE;
        if (offset < vid_addr_t'(65536)) begin
            return mem[offset[15:0]];
        end
        return addr[7:0] ^ addr[15:8] ^ {1'b0, addr[22:16]};
    endfunction

    // Palette index of column x of a displayed line, following the SCB mode and fill bits
    function automatic nibble_t column_index(input int line, input int x);
        nibble_t    quarter [4] = '{4'd8, 4'd12, 4'd0, 4'd4};
        logic [7:0] scb_b;
        logic [7:0] pix_b;
        logic [1:0] col;
        logic [1:0] pair;
        nibble_t    nib;
        scb_b = mem_at(int'(SCB_OFFSET) + line);
        pix_b = mem_at(int'(PIXEL_OFFSET) + int'(LINE_BYTES) * line + x / 4);
        col   = 2'(x % 4);
        // Fill history starts empty on every line
        if (x == 0) begin
            fill_last = 4'd0;
        end
        if (scb_b[7]) begin
            pair = 2'(pix_b >> (3'd6 - {col, 1'b0}));
            return quarter[col] + nibble_t'(pair);
        end
        nib = col[1] ? pix_b[3:0] : pix_b[7:4];
        if (scb_b[5] && nib == 4'd0) begin
            return fill_last;
        end
        if (nib != 4'd0) begin
            fill_last = nib;
        end
        return nib;
    endfunction

    // Entry idx of the palette that the line's SCB selects; red byte follows green and blue
    function automatic rgb12_t palette_color(input int line, input nibble_t idx);
        logic [7:0] scb_b;
        logic [7:0] gb;
        logic [7:0] rb;
        int         base;
        scb_b = mem_at(int'(SCB_OFFSET) + line);
        base  = int'(PALETTE_OFFSET) + 32 * int'(scb_b[3:0]) + 2 * int'(idx);
        gb    = mem_at(base);
        rb    = mem_at(base + 1);
        return {rb[3:0], gb};
    endfunction

    task automatic compare_value(input string what, input logic [31:0] got,
                                 input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("Fail at %0t: %s is %h, expected %h at h_pos %0d v_pos %0d",
                     $time, what, got, expected, h_pos, v_pos);
        end
    endtask

    task automatic check_idle_outputs;
        compare_value("rgb before first step", 32'({red, green, blue}), 32'd0);
        compare_value("addr and irqs before first step",
                      32'({video_addr, scanline_irq, vbl_irq}), 32'd0);
    endtask

    // Outputs registered by the step at (h, v), as seen during the next step
    task automatic check_step(input logic [9:0] h, input logic [8:0] v);
        rgb12_t      exp_c;
        logic [23:0] exp_rgb;
        logic [7:0]  scb_b;
        int          line;
        logic        exp_vbl;
        if (h == 10'd0) begin
            model_border = border_color;
        end
        exp_c = border_table[model_border];
        // Column x is registered at step 33+x and shown during step 34+x
        if (shr_enable && h >= 10'd33 && h <= 10'd672
                && v >= FIRST_VIS_V && v < FIRST_VIS_V + SHR_LINES) begin
            line  = int'(v) - 16;
            exp_c = palette_color(line, column_index(line, int'(h) - 33));
        end
        exp_rgb = {exp_c.r, exp_c.r, exp_c.g, exp_c.g, exp_c.b, exp_c.b};
        compare_value("rgb", 32'({red, green, blue}), 32'(exp_rgb));
        if (h == SCB_LATCH_H) begin
            scb_b     = mem_at(int'(SCB_OFFSET) + int'(v) - 15);
            model_irq = shr_enable && v >= 9'd15 && v < 9'd215 && scb_b[6];
        end else if (h == PAL_START_H) begin
            model_irq = 1'b0;
        end
        compare_value("scanline_irq", 32'(scanline_irq), 32'(model_irq));
        exp_vbl = h == 10'd0 && v == VBL_V;
        compare_value("vbl_irq", 32'(vbl_irq), 32'(exp_vbl));
        if (vbl_irq) begin
            vbl_seen++;
        end
        if (h == SCB_FETCH_H && v >= 9'd15 && v < 9'd215) begin
            compare_value("SCB address", 32'(video_addr),
                          32'(BASE + vid_addr_t'(SCB_OFFSET) + vid_addr_t'(v - 9'd15)));
        end
    endtask

    // Beam moves one position per step, with a new enable for each frame
    task automatic advance_beam;
        if (h_pos == 10'(LINE_LEN - 1)) begin
            h_pos = 10'd0;
            if (v_pos == 9'(FRAME_LINES - 1)) begin
                v_pos      = 9'd0;
                frames     = frames + 1;
                shr_enable = 1'($urandom_range(1, 0));
            end else begin
                v_pos = v_pos + 9'd1;
            end
        end else begin
            h_pos = h_pos + 10'd1;
        end
        if (h_pos != 10'd0 && $urandom_range(99, 0) == 0) begin
            border_color = nibble_t'($urandom_range(15, 0));
        end
    endtask

    initial begin
        void'($urandom(32'hb435_fde7));
        reset        = 1'b1;
        ce_pix       = 1'b0;
        h_pos        = 10'd0;
        v_pos        = 9'd0;
        shr_enable   = 1'b0;
        border_color = 4'd0;
        video_data   = 8'd0;
        addr_held    = '0;
        model_border = 4'd0;
        fill_last    = 4'd0;
        model_irq    = 1'b0;
        stepped      = 1'b0;
        errors       = 0;
        checks       = 0;
        frames       = 0;
        vbl_seen     = 0;
        // Pixels, palettes and SCBs all come from the same random image
        for (int i = 0; i < 65536; i++) begin
            mem[16'(i)] = 8'($urandom);
        end
        repeat (8) begin
            @(posedge clk_vid);
            #1;
            check_idle_outputs();
        end
        reset      = 1'b0;
        shr_enable = 1'($urandom_range(1, 0));
        ce_pix     = 1'($urandom_range(1, 0));
        while (frames < FRAMES) begin
            @(posedge clk_vid);
            #1;
            if (ce_pix) begin
                stepped = 1'b1;
                check_step(h_pos, v_pos);
                // Data of the next step is the byte addressed during this one
                video_data = memory_read(addr_held);
                addr_held  = video_addr;
                advance_beam();
            end else if (!stepped) begin
                check_idle_outputs();
            end
            ce_pix = 1'($urandom_range(1, 0));
        end
        checks++;
        if (vbl_seen != FRAMES) begin
            errors++;
            $display("vbl_irq pulsed %0d times over %0d frames", vbl_seen, FRAMES);
        end
        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/shr_vgc_checker.sv
`default_nettype none

module shr_vgc_checker import vgc_pkg::*; (
    input wire logic       clk_vid,
    input wire logic       reset,
    input wire logic       ce_pix,
    input wire logic       shr_enable,
    input wire vid_addr_t  video_addr,
    input wire logic [7:0] red,
    input wire logic [7:0] green,
    input wire logic [7:0] blue,
    input wire logic       scanline_irq,
    input wire logic       vbl_irq
);
    timeunit 1ns;
    timeprecision 1ps;

    // The blanking pulse lasts one step, so the step that sees it clears it
    vbl_one_step: assert property (@(posedge clk_vid) disable iff (reset)
        (ce_pix && vbl_irq) |=> !vbl_irq)
        else $error("vbl_irq high on two consecutive steps");

    // Scanline interrupts exist only while Super Hi-Res is on
    irq_needs_enable: assert property (@(posedge clk_vid) disable iff (reset)
        !shr_enable |-> !scanline_irq)
        else $error("scanline_irq high with shr_enable low");

    // All state moves on steps, nothing changes in between
    hold_between_steps: assert property (@(posedge clk_vid) disable iff (reset)
        !ce_pix |=> $stable({video_addr, red, green, blue, scanline_irq, vbl_irq}))
        else $error("outputs changed on a clock without ce_pix");

    addr_known: assert property (@(posedge clk_vid) disable iff (reset)
        !$isunknown(video_addr))
        else $error("video_addr has unknown bits");

endmodule

`default_nettype wire

//--- logic/shr_vgc.sv
`default_nettype none

module shr_vgc import vgc_pkg::*; #(
    parameter vid_addr_t MEM_BASE = 23'h10000
) (
    input  wire logic       clk_vid,
    input  wire logic       reset,
    input  wire logic       ce_pix,
    input  wire logic [9:0] h_pos,
    input  wire logic [8:0] v_pos,
    input  wire logic       shr_enable,
    input  wire nibble_t    border_color,
    input  wire logic [7:0] video_data,
    output vid_addr_t       video_addr,
    output logic [7:0]      red,
    output logic [7:0]      green,
    output logic [7:0]      blue,
    output logic            scanline_irq,
    output logic            vbl_irq
);

    logic [7:0] scb;
    logic       pal_we;
    nibble_t    pal_entry;
    logic       pal_red_byte;
    nibble_t    pix_index;
    rgb12_t     pix_color;

    // Address generation, SCB capture and palette load control
    shr_fetch_sequencer #(
        .MEM_BASE (MEM_BASE)
    ) u_fetch (
        .clk_vid      (clk_vid),
        .reset        (reset),
        .ce_pix       (ce_pix),
        .h_pos        (h_pos),
        .v_pos        (v_pos),
        .shr_enable   (shr_enable),
        .video_data   (video_data),
        .video_addr   (video_addr),
        .scb          (scb),
        .scanline_irq (scanline_irq),
        .pal_we       (pal_we),
        .pal_entry    (pal_entry),
        .pal_red_byte (pal_red_byte)
    );

    shr_palette_ram u_palette (
        .clk_vid      (clk_vid),
        .reset        (reset),
        .ce_pix       (ce_pix),
        .pal_we       (pal_we),
        .pal_entry    (pal_entry),
        .pal_red_byte (pal_red_byte),
        .video_data   (video_data),
        .rd_index     (pix_index),
        .rd_color     (pix_color)
    );

    shr_pixel_decoder u_decoder (
        .clk_vid    (clk_vid),
        .reset      (reset),
        .ce_pix     (ce_pix),
        .h_pos      (h_pos),
        .scb        (scb),
        .video_data (video_data),
        .pix_index  (pix_index)
    );

    // Border, window and the final colour register
    vgc_raster_out u_raster (
        .clk_vid      (clk_vid),
        .reset        (reset),
        .ce_pix       (ce_pix),
        .h_pos        (h_pos),
        .v_pos        (v_pos),
        .shr_enable   (shr_enable),
        .border_color (border_color),
        .pix_color    (pix_color),
        .red          (red),
        .green        (green),
        .blue         (blue),
        .vbl_irq      (vbl_irq)
    );

endmodule

`default_nettype wire

//--- logic/vgc_raster_out.sv
`default_nettype none

module vgc_raster_out import vgc_pkg::*; (
    input  wire logic       clk_vid,
    input  wire logic       reset,
    input  wire logic       ce_pix,
    input  wire logic [9:0] h_pos,
    input  wire logic [8:0] v_pos,
    input  wire logic       shr_enable,
    input  wire nibble_t    border_color,
    input  wire rgb12_t     pix_color,
    output logic [7:0]      red,
    output logic [7:0]      green,
    output logic [7:0]      blue,
    output logic            vbl_irq
);

    nibble_t border_lat;
    nibble_t border_sel;
    rgb12_t  out_color;
    logic    in_window;
    logic    v_blank;
    logic    v_blank_d;

    // Border changes mid-line only show from the next line on
    // The h_pos 0 step itself already uses the new sample
    assign border_sel = (h_pos == 10'd0) ? border_color : border_lat;

    // Decoder and palette add one step, so column x is registered here at step 33+x
    assign in_window = shr_enable
                    && h_pos >= LEFT_H + 10'd1 && h_pos <= LEFT_H + ACTIVE_W
                    && v_pos >= FIRST_VIS_V && v_pos < FIRST_VIS_V + SHR_LINES;

    assign out_color = in_window ? pix_color : border_table[border_sel];

    assign v_blank = v_pos >= VBL_V;

    always_ff @(posedge clk_vid) begin
        if (reset) begin
            border_lat <= '0;
            red        <= '0;
            green      <= '0;
            blue       <= '0;
            v_blank_d  <= 1'b0;
            vbl_irq    <= 1'b0;
        end else if (ce_pix) begin
            if (h_pos == 10'd0) begin
                border_lat <= border_color;
            end
            // Each nibble is repeated to fill the 8-bit component
            red   <= {out_color.r, out_color.r};
            green <= {out_color.g, out_color.g};
            blue  <= {out_color.b, out_color.b};
            // One step pulse on the rising edge of blanking
            v_blank_d <= v_blank;
            vbl_irq   <= v_blank && !v_blank_d;
        end
    end

endmodule

`default_nettype wire

//--- shr/shr_pixel_decoder.sv
`default_nettype none

module shr_pixel_decoder import vgc_pkg::*; (
    input  wire logic       clk_vid,
    input  wire logic       reset,
    input  wire logic       ce_pix,
    input  wire logic [9:0] h_pos,
    input  wire logic [7:0] scb,
    input  wire logic [7:0] video_data,
    output nibble_t         pix_index
);

    shr_mode_e  mode;
    logic       fill_on;
    logic       in_pixels;
    logic [9:0] col;
    nibble_t    nib_320;
    nibble_t    idx_640;
    nibble_t    fill_src;
    nibble_t    last_pix;
    nibble_t    next_index;

    assign mode    = shr_mode_e'(scb[7]);
    // Fill mode has no meaning for 640 lines
    assign fill_on = scb[5] && mode == MODE_320;

    assign col       = h_pos - LEFT_H;
    assign in_pixels = h_pos >= LEFT_H && h_pos < LEFT_H + ACTIVE_W;

    // Two columns per nibble in 320 mode, high nibble first
    assign nib_320 = col[1] ? video_data[3:0] : video_data[7:4];

    // In 640 mode each pair of bits picks from one quarter of the palette
    always_comb begin
        case (col[1:0])
            2'd0:    idx_640 = {2'b10, video_data[7:6]};
            2'd1:    idx_640 = {2'b11, video_data[5:4]};
            2'd2:    idx_640 = {2'b00, video_data[3:2]};
            default: idx_640 = {2'b01, video_data[1:0]};
        endcase
    end

    // At the first column nothing has been drawn on this line yet
    assign fill_src = (h_pos == LEFT_H) ? nibble_t'(0) : last_pix;

    always_comb begin
        if (mode == MODE_640) begin
            next_index = idx_640;
        end else if (fill_on && nib_320 == 4'd0) begin
            next_index = fill_src;
        end else begin
            next_index = nib_320;
        end
    end

    always_ff @(posedge clk_vid) begin
        if (reset) begin
            pix_index <= '0;
            last_pix  <= '0;
        end else if (ce_pix && in_pixels) begin
            pix_index <= next_index;
            // Step 32 restarts the history, keeping only a non-zero first nibble
            if (h_pos == LEFT_H) begin
                last_pix <= nib_320;
            end else if (nib_320 != 4'd0) begin
                last_pix <= nib_320;
            end
        end
    end

endmodule

`default_nettype wire

//--- shr/shr_palette_ram.sv
`default_nettype none

module shr_palette_ram import vgc_pkg::*; (
    input  wire logic       clk_vid,
    input  wire logic       reset,
    input  wire logic       ce_pix,
    input  wire logic       pal_we,
    input  wire nibble_t    pal_entry,
    input  wire logic       pal_red_byte,
    input  wire logic [7:0] video_data,
    input  wire nibble_t    rd_index,
    output rgb12_t          rd_color
);

    // Components are kept apart since a single write never touches all three
    nibble_t red_mem   [16];
    nibble_t green_mem [16];
    nibble_t blue_mem  [16];

    always_ff @(posedge clk_vid) begin
        if (reset) begin
            for (int i = 0; i < 16; i++) begin
                red_mem[i]   <= '0;
                green_mem[i] <= '0;
                blue_mem[i]  <= '0;
            end
        end else if (ce_pix && pal_we) begin
            if (pal_red_byte) begin
                // Upper nibble of the red byte is unused
                red_mem[pal_entry] <= video_data[3:0];
            end else begin
                green_mem[pal_entry] <= video_data[7:4];
                blue_mem[pal_entry]  <= video_data[3:0];
            end
        end
    end

    // Read is combinational so the decoder index sees its colour in the same step
    assign rd_color = {red_mem[rd_index], green_mem[rd_index], blue_mem[rd_index]};

endmodule

`default_nettype wire

//--- shr/shr_fetch_sequencer.sv
`default_nettype none

module shr_fetch_sequencer import vgc_pkg::*; #(
    parameter vid_addr_t MEM_BASE = 23'h10000
) (
    input  wire logic       clk_vid,
    input  wire logic       reset,
    input  wire logic       ce_pix,
    input  wire logic [9:0] h_pos,
    input  wire logic [8:0] v_pos,
    input  wire logic       shr_enable,
    input  wire logic [7:0] video_data,
    output vid_addr_t       video_addr,
    output logic [7:0]      scb,
    output logic            scanline_irq,
    output logic            pal_we,
    output nibble_t         pal_entry,
    output logic            pal_red_byte
);

    // The line is 916 steps long, so this is the step just before h_pos wraps
    localparam logic [9:0] LAST_H = 10'd915;

    // The pixel address moves on at byte column 2 of bytes 0 to 158
    localparam logic [9:0] LAST_BYTE_COL = (LINE_BYTES - 10'd1) * 10'd4;

    fetch_phase_e phase;
    logic [8:0]   scb_line;
    logic [8:0]   pix_line;
    logic [9:0]   pix_col;
    vid_addr_t    scb_addr;
    vid_addr_t    pal_base;
    vid_addr_t    pix_base;
    logic         irq_req;
    logic         pix_advance;

    // The SCB fetched on one line belongs to the line displayed after it
    assign scb_line = v_pos - (FIRST_VIS_V - 9'd1);
    assign pix_line = v_pos - FIRST_VIS_V;
    assign pix_col  = h_pos - LEFT_H;

    assign scb_addr = MEM_BASE + vid_addr_t'(SCB_OFFSET) + vid_addr_t'(scb_line);
    // Palettes are 32 bytes apart, chosen by the low SCB nibble
    assign pal_base = MEM_BASE + vid_addr_t'(PALETTE_OFFSET) + vid_addr_t'({scb[3:0], 5'b00000});
    assign pix_base = MEM_BASE + vid_addr_t'(PIXEL_OFFSET)
                    + vid_addr_t'(pix_line) * vid_addr_t'(LINE_BYTES);

    // The palette stream wraps round the end of the line into the left border
    always_comb begin
        if (h_pos >= SCB_FETCH_H && h_pos < PAL_START_H) begin
            phase = FETCH_SCB;
        end else if (h_pos >= PAL_START_H || h_pos < LEFT_H) begin
            phase = FETCH_PALETTE;
        end else if (h_pos < LEFT_H + ACTIVE_W) begin
            phase = FETCH_PIXELS;
        end else begin
            phase = FETCH_IDLE;
        end
    end

    // Interrupt lines run from the SCB fetch for line 0 to the one for line 199
    assign irq_req = video_data[6] && shr_enable
                  && v_pos >= FIRST_VIS_V - 9'd1
                  && v_pos < FIRST_VIS_V + SHR_LINES - 9'd1;

    // Each pixel byte is on the bus for four steps; its successor is addressed one step early
    assign pix_advance = pix_col[1:0] == 2'd2 && pix_col < LAST_BYTE_COL;

    // Palette bytes arrive at h_pos 0 to 31, even bytes hold green and blue, odd ones red
    assign pal_we       = phase == FETCH_PALETTE && h_pos < PAL_BYTES;
    assign pal_entry    = nibble_t'(h_pos[4:1]);
    assign pal_red_byte = h_pos[0];

    always_ff @(posedge clk_vid) begin
        if (reset) begin
            video_addr   <= '0;
            scb          <= '0;
            scanline_irq <= 1'b0;
        end else if (ce_pix) begin
            case (phase)
                FETCH_SCB: begin
                    // Memory answers one step later, so the SCB is on the bus at the latch step
                    if (h_pos == SCB_FETCH_H) begin
                        video_addr <= scb_addr;
                    end
                    if (h_pos == SCB_LATCH_H) begin
                        scb          <= video_data;
                        scanline_irq <= irq_req;
                    end
                end
                FETCH_PALETTE: begin
                    if (h_pos == PAL_START_H) begin
                        video_addr   <= pal_base;
                        scanline_irq <= 1'b0;
                    end else if (h_pos == LEFT_H - 10'd2) begin
                        // Pixel byte 0 must be addressed during the step before h_pos 32
                        video_addr <= pix_base;
                    end else if (h_pos == LAST_H || h_pos < LEFT_H - 10'd2) begin
                        // Byte k is addressed during step k-1 and read at step k
                        video_addr <= video_addr + vid_addr_t'(1);
                    end
                end
                FETCH_PIXELS: begin
                    if (pix_advance) begin
                        video_addr <= video_addr + vid_addr_t'(1);
                    end
                end
                default: begin
                    // Address holds through the right border
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- common/vgc_pkg.sv
`default_nettype none

package vgc_pkg;

    // Byte address into video memory, wide enough for the whole bank space
    typedef logic [22:0] vid_addr_t;

    // One colour component, or one palette index
    typedef logic [3:0] nibble_t;

    // Palette and border colours are kept as red, green, blue nibbles
    typedef struct packed {
        nibble_t r;
        nibble_t g;
        nibble_t b;
    } rgb12_t;

    // SCB bit 7 selects the horizontal resolution of a line
    typedef enum logic {
        MODE_320 = 1'b0,
        MODE_640 = 1'b1
    } shr_mode_e;

    // Part of the scanline that the fetch sequencer is working on
    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_SCB,
        FETCH_PALETTE,
        FETCH_PIXELS
    } fetch_phase_e;

    // Horizontal steps of the SCB and palette fetch near the end of a line
    localparam logic [9:0] SCB_FETCH_H = 10'd908;
    localparam logic [9:0] SCB_LATCH_H = 10'd910;
    localparam logic [9:0] PAL_START_H = 10'd912;

    // One palette is 16 entries of two bytes
    localparam logic [9:0] PAL_BYTES = 10'd32;

    // Vertical layout of the Super Hi-Res frame
    localparam logic [8:0] FIRST_VIS_V = 9'd16;
    localparam logic [8:0] SHR_LINES   = 9'd200;
    localparam logic [8:0] VBL_V       = 9'd208;

    // Horizontal layout of the pixel stream
    localparam logic [9:0] LINE_BYTES = 10'd160;
    localparam logic [9:0] LEFT_H     = 10'd32;
    localparam logic [9:0] ACTIVE_W   = 10'd640;

    // Offsets of the three regions of the Super Hi-Res buffer from the bank base
    localparam logic [15:0] PIXEL_OFFSET   = 16'h2000;
    localparam logic [15:0] SCB_OFFSET     = 16'h9D00;
    localparam logic [15:0] PALETTE_OFFSET = 16'h9E00;

    // Border colours follow the IIgs lores colour set, indexed by the border register
    localparam rgb12_t border_table [16] = '{
        12'h000,
        // Deep red
        12'hd03,
        12'h009,
        // Purple
        12'hd0d,
        12'h070,
        // Dark grey
        12'h555,
        12'h22f,
        // Light blue
        12'h6af,
        12'h852,
        // Orange
        12'hf60,
        12'haaa,
        // Pink
        12'hf98,
        12'h0d0,
        // Yellow
        12'hff0,
        12'h0f9,
        // White
        12'hfff
    };

endpackage

`default_nettype wire
